// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_dcache_top
FILELIST = dcache_top.f
BIN      = obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with $(SIM) and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir

// ==== dcache_top.f ====
src/dcache_pkg.sv
src/dcache_cfg_regs.sv
src/dcache_array.sv
src/dcache_ctrl.sv
src/dcache_top.sv
testbench/dcache_props.sv
testbench/tb_dcache_top.sv

// ==== src/dcache_array.sv ====
// two-way tag, valid and data storage private to the controller
// read result appears one cycle after rd_i; a fill picks its own way
// fill and store in the same cycle to the same way is not expected

module dcache_array (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // lookup
  input  logic                                rd_i,
  input  logic [dcache_pkg::INDEX_WIDTH-1:0]  rd_index_i,
  input  logic [dcache_pkg::TAG_WIDTH-1:0]    rd_tag_i,
  output logic [dcache_pkg::NR_WAYS-1:0]      hit_way_o,
  output dcache_pkg::line_t                   rd_line_o,
  // byte-enabled store to a hitting way
  input  logic                                st_i,
  input  logic [dcache_pkg::NR_WAYS-1:0]      st_way_i,
  input  logic [dcache_pkg::INDEX_WIDTH-1:0]  st_index_i,
  input  logic [dcache_pkg::LINE_BYTES-1:0]   st_be_i,
  input  dcache_pkg::line_t                   st_line_i,
  // whole-line refill
  input  logic                                fill_i,
  input  logic [dcache_pkg::INDEX_WIDTH-1:0]  fill_index_i,
  input  logic [dcache_pkg::TAG_WIDTH-1:0]    fill_tag_i,
  input  dcache_pkg::line_t                   fill_line_i,
  input  logic                                flush_i
);
  import dcache_pkg::*;

  logic  [NR_SETS-1:0][NR_WAYS-1:0]       valid_q;
  logic  [NR_SETS-1:0][WAY_IDX_WIDTH-1:0] rr_q;
  logic  [TAG_WIDTH-1:0]                  tag_q  [NR_WAYS][NR_SETS];
  line_t                                  data_q [NR_WAYS][NR_SETS];

  logic [INDEX_WIDTH-1:0] rd_index_q;
  logic [TAG_WIDTH-1:0]   rd_tag_q;
  logic [NR_WAYS-1:0]     fill_way;
  logic                   free_found;

  // ----------------------------------------
  // tag compare on the registered lookup
  // ----------------------------------------
  always_comb begin
    logic way_hit;
    rd_line_o = '0;
    hit_way_o = '0;
    for (int unsigned w = 0; w < NR_WAYS; w++) begin
      way_hit      = valid_q[rd_index_q][w] && (tag_q[w][rd_index_q] == rd_tag_q);
      hit_way_o[w] = way_hit;
      if (way_hit) rd_line_o = data_q[w][rd_index_q];
    end
  end

  // victim: first invalid way, else round robin of the set
  always_comb begin
    fill_way   = '0;
    free_found = 1'b0;
    for (int unsigned w = 0; w < NR_WAYS; w++) begin
      if (!free_found && !valid_q[fill_index_i][w]) begin
        fill_way[w] = 1'b1;
        free_found  = 1'b1;
      end
    end
    if (!free_found) fill_way[rr_q[fill_index_i]] = 1'b1;
  end

  // ----------------------------------------
  // valid bits and replacement state
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_i) begin
      valid_q[fill_index_i] <= valid_q[fill_index_i] | fill_way;
      // only move the pointer when a valid line was replaced
      if (!free_found) rr_q[fill_index_i] <= rr_q[fill_index_i] + 1'b1;
    end
  end

  // storage and lookup address
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      rd_index_q <= rd_index_i;
      rd_tag_q   <= rd_tag_i;
    end
    for (int unsigned w = 0; w < NR_WAYS; w++) begin
      if (fill_i && fill_way[w]) begin
        tag_q[w][fill_index_i]  <= fill_tag_i;
        data_q[w][fill_index_i] <= fill_line_i;
      end else if (st_i && st_way_i[w]) begin
        for (int unsigned b = 0; b < LINE_BYTES; b++) begin
          if (st_be_i[b]) data_q[w][st_index_i][b*8 +: 8] <= st_line_i[b*8 +: 8];
        end
      end
    end
  end

endmodule

// ==== src/dcache_cfg_regs.sv ====
// cache enable and cacheable region registers, write-only from outside
// a write takes effect on the next cycle; flush pulses once per 0->1 enable

module dcache_cfg_regs (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  cfg_we_i,
  input  logic [dcache_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr_i,
  input  logic [dcache_pkg::XLEN-1:0]           cfg_wdata_i,
  output dcache_pkg::cache_cfg_t                cfg_o,
  output logic                                  flush_o
);
  import dcache_pkg::*;

  cache_cfg_t cfg_q;
  logic       flush_q;
  logic       enable_rise;

  // enable written to 1 while currently off
  assign enable_rise = cfg_we_i && (cfg_addr_i == CFG_ENABLE_ADDR)
                       && cfg_wdata_i[0] && !cfg_q.enable;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // disabled, region covers everything but bypass wins
      cfg_q   <= '0;
      flush_q <= 1'b0;
    end else begin
      flush_q <= enable_rise;
      if (cfg_we_i) begin
        case (cfg_addr_i)
          CFG_ENABLE_ADDR: cfg_q.enable      <= cfg_wdata_i[0];
          CFG_BASE_ADDR:   cfg_q.region_base <= cfg_wdata_i[TAG_WIDTH-1:0];
          CFG_MASK_ADDR:   cfg_q.region_mask <= cfg_wdata_i[TAG_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  assign cfg_o   = cfg_q;
  // lines in the array may be stale after bypass writes
  assign flush_o = flush_q;

endmodule

// ==== src/dcache_ctrl.sv ====
// request FSM for one core load/store port, one miss outstanding at a time
// stores are write-through, no-allocate; only loads pipeline behind a hit
// bypass decision is taken once at acceptance and kept with the request

module dcache_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // core port
  input  dcache_pkg::core_req_t               core_req_i,
  output dcache_pkg::core_rsp_t               core_rsp_o,
  input  dcache_pkg::cache_cfg_t              cfg_i,
  // memory port
  output dcache_pkg::miss_req_t               miss_req_o,
  input  logic                                miss_gnt_i,
  input  logic                                refill_valid_i,
  input  dcache_pkg::line_t                   refill_line_i,
  // array lookup
  output logic                                rd_o,
  output logic [dcache_pkg::INDEX_WIDTH-1:0]  rd_index_o,
  output logic [dcache_pkg::TAG_WIDTH-1:0]    rd_tag_o,
  input  logic [dcache_pkg::NR_WAYS-1:0]      hit_way_i,
  input  dcache_pkg::line_t                   rd_line_i,
  // array store
  output logic                                st_o,
  output logic [dcache_pkg::NR_WAYS-1:0]      st_way_o,
  output logic [dcache_pkg::INDEX_WIDTH-1:0]  st_index_o,
  output logic [dcache_pkg::LINE_BYTES-1:0]   st_be_o,
  output dcache_pkg::line_t                   st_line_o,
  // array fill
  output logic                                fill_o,
  output logic [dcache_pkg::INDEX_WIDTH-1:0]  fill_index_o,
  output logic [dcache_pkg::TAG_WIDTH-1:0]    fill_tag_o,
  output dcache_pkg::line_t                   fill_line_o
);
  import dcache_pkg::*;

  typedef enum logic [1:0] {IDLE, LOOKUP, MISS_REQ, WAIT_REFILL} state_e;

  // request as accepted, plus its bypass decision
  typedef struct packed {
    logic                  we;
    logic [XLEN_BYTES-1:0] be;
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    logic [XLEN-1:0]       wdata;
    logic                  bypass;
  } saved_req_t;

  state_e     state_d, state_q;
  saved_req_t req_d, req_q;

  logic [TAG_WIDTH-1:0]      new_tag;
  logic                      new_bypass;
  logic                      accept;
  logic                      hit;
  logic [WORD_SEL_WIDTH-1:0] word_sel;
  logic [LINE_BYTES-1:0]     lane_be;
  line_t                     lane_data;

  function automatic logic [XLEN-1:0] pick_word(line_t line, logic [WORD_SEL_WIDTH-1:0] sel);
    return line[sel*XLEN +: XLEN];
  endfunction

  // ----------------------------------------
  // address split and lane placement
  // ----------------------------------------
  assign new_tag    = core_req_i.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  // uncacheable when any masked tag bit differs from the base
  assign new_bypass = !cfg_i.enable
                      || (((new_tag ^ cfg_i.region_base) & cfg_i.region_mask) != '0);

  assign rd_index_o = core_req_i.addr[OFFSET_WIDTH +: INDEX_WIDTH];
  assign rd_tag_o   = new_tag;

  assign word_sel = req_q.addr[OFFSET_WIDTH-1 -: WORD_SEL_WIDTH];
  // hit_way_i stays valid until the next rd_o, so it covers MISS_REQ too
  assign hit      = (|hit_way_i) && !req_q.bypass;

  always_comb begin
    lane_be   = '0;
    lane_data = '0;
    lane_be[word_sel*XLEN_BYTES +: XLEN_BYTES] = req_q.be;
    lane_data[word_sel*XLEN +: XLEN]           = req_q.wdata;
  end

  assign st_way_o     = hit_way_i;
  assign st_index_o   = req_q.addr[OFFSET_WIDTH +: INDEX_WIDTH];
  assign st_be_o      = lane_be;
  assign st_line_o    = lane_data;
  assign fill_index_o = req_q.addr[OFFSET_WIDTH +: INDEX_WIDTH];
  assign fill_tag_o   = req_q.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
  assign fill_line_o  = refill_line_i;

  // ----------------------------------------
  // FSM
  // ----------------------------------------
  always_comb begin
    state_d        = state_q;
    req_d          = req_q;
    accept         = 1'b0;
    rd_o           = 1'b0;
    st_o           = 1'b0;
    fill_o         = 1'b0;
    core_rsp_o     = '0;
    core_rsp_o.rid = req_q.id;
    miss_req_o     = '0;

    case (state_q)
      IDLE: begin
        // loads granted now, stores only with their write-through
        if (core_req_i.valid) begin
          accept         = 1'b1;
          core_rsp_o.gnt = !core_req_i.we;
          state_d        = LOOKUP;
        end
      end

      LOOKUP, MISS_REQ: begin
        if (state_q == LOOKUP && !req_q.we && hit) begin
          core_rsp_o.rvalid = 1'b1;
          core_rsp_o.rdata  = pick_word(rd_line_i, word_sel);
          state_d           = IDLE;
          // next load overlaps with this rvalid
          if (core_req_i.valid && !core_req_i.we) begin
            accept         = 1'b1;
            core_rsp_o.gnt = 1'b1;
            state_d        = LOOKUP;
          end
        end else begin
          // miss, bypass or store: held until miss_gnt_i
          miss_req_o.valid  = 1'b1;
          miss_req_o.bypass = req_q.bypass;
          miss_req_o.we     = req_q.we;
          miss_req_o.addr   = {req_q.addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
          miss_req_o.be     = lane_be;
          miss_req_o.wdata  = lane_data;
          state_d           = MISS_REQ;
          if (miss_gnt_i) begin
            if (req_q.we) begin
              core_rsp_o.gnt = 1'b1;
              // keep a cached copy coherent with memory
              st_o           = hit;
              state_d        = IDLE;
            end else begin
              state_d = WAIT_REFILL;
            end
          end
        end
      end

      WAIT_REFILL: begin
        if (refill_valid_i) begin
          core_rsp_o.rvalid = 1'b1;
          core_rsp_o.rdata  = pick_word(refill_line_i, word_sel);
          fill_o            = !req_q.bypass;
          state_d           = IDLE;
        end
      end

      default: state_d = IDLE;
    endcase

    // capture the new request and start its lookup
    if (accept) begin
      req_d.we     = core_req_i.we;
      req_d.be     = core_req_i.be;
      req_d.id     = core_req_i.id;
      req_d.addr   = core_req_i.addr;
      req_d.wdata  = core_req_i.wdata;
      req_d.bypass = new_bypass;
      rd_o         = !new_bypass;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      req_q   <= '0;
    end else begin
      state_q <= state_d;
      req_q   <= req_d;
    end
  end

endmodule

// ==== src/dcache_pkg.sv ====
// shared geometry and bus structs for the two-way data cache
// line size, index and tag widths are fixed; addresses are byte addresses
// config registers hold the region as tag values, not full addresses

package dcache_pkg;

  // ----------------------------------------
  // geometry
  // ----------------------------------------
  localparam int unsigned XLEN           = 32;
  localparam int unsigned LINE_WIDTH     = 128;
  localparam int unsigned NR_WAYS        = 2;
  localparam int unsigned OFFSET_WIDTH   = 4;
  localparam int unsigned INDEX_WIDTH    = 6;
  localparam int unsigned TAG_WIDTH      = 22;
  localparam int unsigned ADDR_WIDTH     = 32;
  localparam int unsigned ID_WIDTH       = 4;
  localparam int unsigned CFG_ADDR_WIDTH = 2;

  // derived sizes
  localparam int unsigned NR_SETS        = 1 << INDEX_WIDTH;
  localparam int unsigned LINE_BYTES     = LINE_WIDTH / 8;
  localparam int unsigned XLEN_BYTES     = XLEN / 8;
  localparam int unsigned WORD_SEL_WIDTH = $clog2(LINE_WIDTH / XLEN);
  localparam int unsigned WAY_IDX_WIDTH  = (NR_WAYS > 1) ? $clog2(NR_WAYS) : 1;

  // config register map, enable sits in bit 0 of its word
  localparam logic [CFG_ADDR_WIDTH-1:0] CFG_ENABLE_ADDR = 2'd0;
  localparam logic [CFG_ADDR_WIDTH-1:0] CFG_BASE_ADDR   = 2'd1;
  localparam logic [CFG_ADDR_WIDTH-1:0] CFG_MASK_ADDR   = 2'd2;

  // ----------------------------------------
  // types
  // ----------------------------------------
  typedef logic [LINE_WIDTH-1:0] line_t;

  // core request, held stable until gnt
  typedef struct packed {
    logic                    valid;
    logic                    we;
    logic [XLEN_BYTES-1:0]   be;
    logic [ID_WIDTH-1:0]     id;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [XLEN-1:0]         wdata;
  } core_req_t;

  typedef struct packed {
    logic                    gnt;
    logic                    rvalid;
    logic [ID_WIDTH-1:0]     rid;
    logic [XLEN-1:0]         rdata;
  } core_rsp_t;

  // line-aligned request to memory, word placed in its lane
  typedef struct packed {
    logic                    valid;
    logic                    bypass;
    logic                    we;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [LINE_BYTES-1:0]   be;
    line_t                   wdata;
  } miss_req_t;

  // cacheable when (tag ^ region_base) & region_mask is zero
  typedef struct packed {
    logic                    enable;
    logic [TAG_WIDTH-1:0]    region_base;
    logic [TAG_WIDTH-1:0]    region_mask;
  } cache_cfg_t;

endpackage

// ==== src/dcache_top.sv ====
// data cache top: config registers, controller and private array
// one core port in, one memory port out; refill always returns a whole line

module dcache_top (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // core port
  input  dcache_pkg::core_req_t                 core_req_i,
  output dcache_pkg::core_rsp_t                 core_rsp_o,
  // config writes
  input  logic                                  cfg_we_i,
  input  logic [dcache_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr_i,
  input  logic [dcache_pkg::XLEN-1:0]           cfg_wdata_i,
  // memory port
  output dcache_pkg::miss_req_t                 miss_req_o,
  input  logic                                  miss_gnt_i,
  input  logic                                  refill_valid_i,
  input  dcache_pkg::line_t                     refill_line_i
);
  import dcache_pkg::*;

  cache_cfg_t             cfg;
  logic                   flush;
  logic                   rd;
  logic [INDEX_WIDTH-1:0] rd_index;
  logic [TAG_WIDTH-1:0]   rd_tag;
  logic [NR_WAYS-1:0]     hit_way;
  line_t                  rd_line;
  logic                   st;
  logic [NR_WAYS-1:0]     st_way;
  logic [INDEX_WIDTH-1:0] st_index;
  logic [LINE_BYTES-1:0]  st_be;
  line_t                  st_line;
  logic                   fill;
  logic [INDEX_WIDTH-1:0] fill_index;
  logic [TAG_WIDTH-1:0]   fill_tag;
  line_t                  fill_line;

  dcache_cfg_regs i_cfg_regs (
    .clk_i, .rst_ni, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i,
    .cfg_o   (cfg),
    .flush_o (flush)
  );

  dcache_ctrl i_ctrl (
    .clk_i, .rst_ni, .core_req_i, .core_rsp_o,
    .cfg_i        (cfg),
    .miss_req_o, .miss_gnt_i, .refill_valid_i, .refill_line_i,
    .rd_o         (rd),       .rd_index_o  (rd_index),  .rd_tag_o   (rd_tag),
    .hit_way_i    (hit_way),  .rd_line_i   (rd_line),
    .st_o         (st),       .st_way_o    (st_way),    .st_index_o (st_index),
    .st_be_o      (st_be),    .st_line_o   (st_line),
    .fill_o       (fill),     .fill_index_o(fill_index),
    .fill_tag_o   (fill_tag), .fill_line_o (fill_line)
  );

  dcache_array i_array (
    .clk_i, .rst_ni,
    .rd_i         (rd),       .rd_index_i  (rd_index),  .rd_tag_i   (rd_tag),
    .hit_way_o    (hit_way),  .rd_line_o   (rd_line),
    .st_i         (st),       .st_way_i    (st_way),    .st_index_i (st_index),
    .st_be_i      (st_be),    .st_line_i   (st_line),
    .fill_i       (fill),     .fill_index_i(fill_index),
    .fill_tag_i   (fill_tag), .fill_line_i (fill_line),
    .flush_i      (flush)
  );

endmodule

// ==== testbench/dcache_props.sv ====
// port protocol checks, bound into every dcache_ctrl
// a load that misses or bypasses shows a miss request in place of rvalid

module dcache_props (
  input logic                   clk_i,
  input logic                   rst_ni,
  input dcache_pkg::core_req_t  core_req_i,
  input dcache_pkg::core_rsp_t  core_rsp_i,
  input dcache_pkg::miss_req_t  miss_req_i,
  input logic                   miss_gnt_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_count = 0;

  // ----------------------------------------
  // miss port
  // ----------------------------------------
  miss_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    miss_req_i.valid && !miss_gnt_i |=> $stable(miss_req_i))
    else begin
      fail_count++;
      $error("miss request changed before it was granted");
    end

  // ----------------------------------------
  // core port
  // ----------------------------------------
  // granted load returns data next cycle unless it went out as a miss
  hit_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    core_rsp_i.gnt && !core_req_i.we |=> core_rsp_i.rvalid || miss_req_i.valid)
    else begin
      fail_count++;
      $error("load hit did not return data one cycle after its grant");
    end

  reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !core_rsp_i.gnt && !core_rsp_i.rvalid && !miss_req_i.valid)
    else begin
      fail_count++;
      $error("outputs active in the first cycle after reset");
    end

  // refill data and a pending miss never coincide
  rvalid_vs_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(core_rsp_i.rvalid && miss_req_i.valid))
    else begin
      fail_count++;
      $error("rvalid given while a miss request is pending");
    end

endmodule

bind dcache_ctrl dcache_props props (
  .clk_i, .rst_ni, .core_req_i,
  .core_rsp_i (core_rsp_o),
  .miss_req_i (miss_req_o),
  .miss_gnt_i
);

// ==== testbench/tb_dcache_top.sv ====
// memory model answers one miss at a time, grant and refill after LCG delays
// expected load data is the address pattern overlaid with granted stores
// inputs change 1 ns after the rising edge, outputs are sampled at the falling edge

module tb_dcache_top;
  timeunit 1ns;
  timeprecision 1ps;
  import dcache_pkg::*;

  // about 13 accesses plus config writes, a slow miss needs at most ~12 cycles
  localparam int unsigned NR_ACCESSES       = 25;
  localparam int unsigned MAX_ACCESS_CYCLES = 16;
  localparam int unsigned TIMEOUT_CYCLES    = 10 * NR_ACCESSES * MAX_ACCESS_CYCLES;
  localparam logic [31:0] ADDR_CACHED       = 32'h8000_0124;
  localparam logic [31:0] ADDR_UNCACHED     = 32'h4000_0208;

  logic       clk = 1'b0;
  logic       rst_n;
  core_req_t  core_req;
  core_rsp_t  core_rsp;
  logic       cfg_we;
  logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
  logic [XLEN-1:0] cfg_wdata;
  miss_req_t  miss_req;
  logic       miss_gnt;
  logic       refill_valid;
  line_t      refill_line;

  logic [31:0]         lcg_state = 32'haf51;
  line_t               mem_lines [logic [31:0]];
  logic [ID_WIDTH-1:0] next_id = '0;
  logic [ID_WIDTH-1:0] exp_id_q [$];
  logic [31:0]         exp_data_q [$];
  miss_req_t           last_miss;
  int unsigned         cycle_count = 0;
  int                  errors = 0;
  int                  miss_count = 0;
  int                  overlap_count = 0;
  int                  tests_run = 0;
  int                  tests_failed = 0;

  dcache_top dut (
    .clk_i (clk), .rst_ni (rst_n),
    .core_req_i (core_req), .core_rsp_o (core_rsp),
    .cfg_we_i (cfg_we), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
    .miss_req_o (miss_req), .miss_gnt_i (miss_gnt),
    .refill_valid_i (refill_valid), .refill_line_i (refill_line)
  );

  always #5 clk = ~clk;

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // every word differs with the full byte address
  function automatic line_t model_line(input logic [31:0] line_addr);
    line_t line;
    if (mem_lines.exists(line_addr)) return mem_lines[line_addr];
    for (int k = 0; k < 4; k++) begin
      line[k*32 +: 32] = ((line_addr + 32'(k * 4)) * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
    end
    return line;
  endfunction

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic expect_true(input bit ok, input string what);
    assert (ok) else begin
      $display("ERROR @%0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic write_cfg(input logic [CFG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    tick();
    cfg_we    = 1'b0;
  endtask

  // hold the request until gnt is seen
  task automatic drive_req(input logic we, input logic [3:0] be,
                           input logic [31:0] addr, input logic [31:0] wdata);
    core_req.valid = 1'b1;
    core_req.we    = we;
    core_req.be    = be;
    core_req.id    = next_id;
    core_req.addr  = addr;
    core_req.wdata = wdata;
    next_id        = next_id + ID_WIDTH'(1);
    @(negedge clk);
    while (!core_rsp.gnt) @(negedge clk);
    tick();
    core_req.valid = 1'b0;
  endtask

  task automatic load(input logic [31:0] addr);
    line_t line;
    line = model_line({addr[31:4], 4'h0});
    exp_id_q.push_back(next_id);
    exp_data_q.push_back(line[int'(addr[3:2])*32 +: 32]);
    drive_req(1'b0, 4'hf, addr, 32'h0);
  endtask

  // wait until every load has returned
  task automatic drain();
    while (exp_id_q.size() != 0) tick();
    tick();
  endtask

  task automatic check_store_miss(input logic [31:0] addr, input logic [3:0] be,
                                  input logic [31:0] wdata, input logic bypass);
    int                    word;
    logic [LINE_BYTES-1:0] want_be;
    word    = int'(addr[3:2]);
    want_be = {{(LINE_BYTES-4){1'b0}}, be} << (4 * word);
    expect_true(last_miss.we && last_miss.bypass == bypass, "store miss has wrong we or bypass");
    expect_true(last_miss.addr == {addr[31:4], 4'h0}, "store miss address not line aligned");
    expect_true(last_miss.be == want_be, "store byte enable not in the word lane");
    expect_true(last_miss.wdata[word*32 +: 32] == wdata, "store data not in the word lane");
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) tests_failed++;
    $display("test %-20s %s", name, (errors == err_before) ? "passed" : "failed");
  endtask

  // ----------------------------------------
  // memory model
  // ----------------------------------------
  initial begin : memory_model
    miss_req_t   req;
    int unsigned delay;
    line_t       line;
    miss_gnt     = 1'b0;
    refill_valid = 1'b0;
    refill_line  = '0;
    forever begin
      @(negedge clk);
      if (rst_n && miss_req.valid) begin
        req   = miss_req;
        delay = lcg_next() % 32'd4;
        repeat (delay + 1) @(posedge clk);
        #1;
        miss_gnt = 1'b1;
        if (req.we) begin
          line = model_line(req.addr);
          for (int b = 0; b < LINE_BYTES; b++) begin
            if (req.be[b]) line[b*8 +: 8] = req.wdata[b*8 +: 8];
          end
          mem_lines[req.addr] = line;
        end
        tick();
        miss_gnt = 1'b0;
        if (!req.we) begin
          delay = 32'd1 + (lcg_next() % 32'd4);
          repeat (delay - 1) tick();
          refill_valid = 1'b1;
          refill_line  = model_line(req.addr);
          tick();
          refill_valid = 1'b0;
        end
      end
    end
  end

  // ----------------------------------------
  // response and miss monitor
  // ----------------------------------------
  always @(negedge clk) begin : monitor
    logic [ID_WIDTH-1:0] want_id;
    logic [31:0]         want_data;
    if (rst_n && core_rsp.rvalid) begin
      if (exp_id_q.size() == 0) begin
        $display("ERROR @%0t: rvalid with no load outstanding", $time);
        errors++;
      end else begin
        want_id   = exp_id_q.pop_front();
        want_data = exp_data_q.pop_front();
        expect_true(core_rsp.rid == want_id, $sformatf("rid %0h, expected %0h",
                    core_rsp.rid, want_id));
        expect_true(core_rsp.rdata == want_data, $sformatf("rdata %08h, expected %08h",
                    core_rsp.rdata, want_data));
      end
    end
    if (rst_n && core_rsp.gnt && core_rsp.rvalid) overlap_count++;
    if (rst_n && miss_req.valid && miss_gnt) begin
      miss_count++;
      last_miss = miss_req;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a request never completed", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  // ----------------------------------------
  // tests
  // ----------------------------------------
  initial begin
    int err_before;
    int miss_before;
    int overlap_before;
    rst_n     = 1'b0;
    core_req  = '0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    tick();

    // disabled after reset, every load bypasses
    err_before  = errors;
    miss_before = miss_count;
    load(ADDR_CACHED);
    drain();
    expect_true(miss_count == miss_before + 1 && last_miss.bypass, "first load did not bypass");
    load(ADDR_CACHED);
    drain();
    expect_true(miss_count == miss_before + 2 && last_miss.bypass, "repeat load did not bypass");
    report_test("reset_bypass", err_before);

    // region covers tags with the top 6 bits of 0x200000
    err_before = errors;
    write_cfg(CFG_BASE_ADDR, 32'h0020_0000);
    write_cfg(CFG_MASK_ADDR, 32'h003f_0000);
    write_cfg(CFG_ENABLE_ADDR, 32'h1);
    miss_before = miss_count;
    load(ADDR_CACHED);
    drain();
    expect_true(miss_count == miss_before + 1 && !last_miss.bypass, "cached load did not refill");
    overlap_before = overlap_count;
    load(32'h8000_0120);
    load(32'h8000_012c);
    load(32'h8000_0128);
    drain();
    expect_true(miss_count == miss_before + 1, "load to a filled line went to memory");
    expect_true(overlap_count >= overlap_before + 2, "back-to-back loads did not overlap");
    report_test("miss_then_hit", err_before);

    // write-through into the cached line, then read the merged bytes
    err_before  = errors;
    miss_before = miss_count;
    drive_req(1'b1, 4'b0110, ADDR_CACHED, 32'hdead_beef);
    check_store_miss(ADDR_CACHED, 4'b0110, 32'hdead_beef, 1'b0);
    load(ADDR_CACHED);
    drain();
    expect_true(miss_count == miss_before + 1, "load after store missed");
    report_test("write_through", err_before);

    err_before  = errors;
    miss_before = miss_count;
    load(ADDR_UNCACHED);
    drain();
    expect_true(miss_count == miss_before + 1 && last_miss.bypass, "uncached load not bypassed");
    load(ADDR_UNCACHED);
    drain();
    expect_true(miss_count == miss_before + 2 && last_miss.bypass, "uncached line was allocated");
    report_test("uncacheable", err_before);

    // stale line must be gone once the cache is enabled again
    err_before = errors;
    write_cfg(CFG_ENABLE_ADDR, 32'h0);
    drive_req(1'b1, 4'hf, ADDR_CACHED, 32'h1234_5678);
    check_store_miss(ADDR_CACHED, 4'hf, 32'h1234_5678, 1'b1);
    write_cfg(CFG_ENABLE_ADDR, 32'h1);
    miss_before = miss_count;
    load(ADDR_CACHED);
    drain();
    expect_true(miss_count == miss_before + 1 && !last_miss.bypass, "no refill after re-enable");
    report_test("flush_reenable", err_before);

    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, dut.i_ctrl.props.fail_count);
    if (errors == 0 && dut.i_ctrl.props.fail_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
